// ==== hw/fetch_addr_pkg.sv ====
// fetch address geometry
package fetch_addr_pkg;

  // full byte address carried through the front end
  localparam int ip_width = 43;

  // fetch lines are 32 bytes
  localparam int line_bytes_log = 5;
  localparam int line_bytes = 1 << line_bytes_log;

  // fall-through increment, sized to the address
  localparam logic [ip_width-1:0] line_step = ip_width'(line_bytes);

endpackage

// ==== hw/branch_pkg.sv ====
// branch prediction constants
package branch_pkg;

  // global history register
  localparam int hist_len = 14;

  // history bits folded into each direction table index
  localparam int hist_len_a = 2;
  localparam int hist_len_b = 8;
  localparam int hist_len_c = 14;
  localparam int num_tables = 3;

  // target buffer ways per fetch line
  localparam int num_slots = 2;
  localparam int slot_bits = $clog2(num_slots);

  // kind field, one flag per bit
  localparam int kind_width = 3;
  localparam int kind_call = 0;
  localparam int kind_ret = 1;
  localparam int kind_uncond = 2;  // forces taken

endpackage

// ==== hw/target_buffer.sv ====
// branch target buffer
`timescale 1ns/1ns

module target_buffer
  import fetch_addr_pkg::*;
  import branch_pkg::*;
#(
  parameter int btb_index_bits = 6
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [ip_width-1:0]   fetch_ip,
  input  logic                  resolve_en,
  input  logic                  resolve_taken,
  input  logic [ip_width-1:0]   resolve_src_ip,
  input  logic [ip_width-1:0]   resolve_target,
  input  logic [slot_bits-1:0]  resolve_slot,
  input  logic [kind_width-1:0] resolve_kind,
  output logic [num_slots-1:0]  hit,
  output logic [ip_width-1:0]   target0,
  output logic [ip_width-1:0]   target1,
  output logic [kind_width-1:0] kind0,
  output logic [kind_width-1:0] kind1
);

  localparam int num_sets = 1 << btb_index_bits;
  localparam int tag_bits = ip_width - line_bytes_log - btb_index_bits;

  logic [btb_index_bits-1:0] rd_set;
  logic [btb_index_bits-1:0] wr_set;
  logic [tag_bits-1:0]       rd_tag;
  logic [tag_bits-1:0]       wr_tag;
  logic                      install;

  logic [ip_width-1:0]   rd_target [num_slots];
  logic [kind_width-1:0] rd_kind [num_slots];

  // set from the bits just above the line offset
  assign rd_set = fetch_ip[line_bytes_log +: btb_index_bits];
  assign rd_tag = fetch_ip[ip_width-1 -: tag_bits];
  assign wr_set = resolve_src_ip[line_bytes_log +: btb_index_bits];
  assign wr_tag = resolve_src_ip[ip_width-1 -: tag_bits];

  // only taken branches earn an entry
  assign install = resolve_en && resolve_taken;

  for (genvar s = 0; s < num_slots; s++) begin : g_slot
    logic [num_sets-1:0]   valid_q;
    logic [tag_bits-1:0]   tag_q [num_sets];
    logic [ip_width-1:0]   target_q [num_sets];
    logic [kind_width-1:0] kind_q [num_sets];
    logic                  slot_wr;

    assign slot_wr = install && resolve_slot == slot_bits'(s);

    always_ff @(posedge clk) begin
      if (rst) begin
        valid_q <= '0;
      end else if (slot_wr) begin
        valid_q[wr_set] <= 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (slot_wr) begin
        tag_q[wr_set]    <= wr_tag;
        target_q[wr_set] <= resolve_target;
        kind_q[wr_set]   <= resolve_kind;
      end
    end

    assign hit[s]       = valid_q[rd_set] && tag_q[rd_set] == rd_tag;
    assign rd_target[s] = target_q[rd_set];
    assign rd_kind[s]   = kind_q[rd_set];

    // an install is seen by the next lookup of the same line
    a_install_visible : assert property (
      @(posedge clk) disable iff (rst)
      slot_wr |=> rd_set != $past(wr_set) || rd_tag != $past(wr_tag) || hit[s]
    ) else $error("target_buffer: install missed by lookup in slot %0d", s);
  end

  assign target0 = rd_target[0];
  assign target1 = rd_target[1];
  assign kind0   = rd_kind[0];
  assign kind1   = rd_kind[1];

endmodule

// ==== hw/direction_predictor.sv ====
// history-hashed direction predictor
`timescale 1ns/1ns

module direction_predictor
  import fetch_addr_pkg::*;
  import branch_pkg::*;
#(
  parameter int pht_index_bits = 6
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [ip_width-1:0]  fetch_ip,
  input  logic [hist_len-1:0]  fetch_hist,
  input  logic                 resolve_en,
  input  logic                 resolve_mispredict,
  input  logic [ip_width-1:0]  resolve_src_ip,
  input  logic [hist_len-1:0]  resolve_hist,
  input  logic [slot_bits-1:0] resolve_slot,
  output logic [num_slots-1:0] dir
);

  localparam int num_entries = 1 << pht_index_bits;
  localparam int ptr_bits = $clog2(num_tables);

  logic [ptr_bits-1:0]  upd_ptr;  // table to flip on the next mispredict
  logic                 upd_en;
  logic [num_slots-1:0] rd_bits [num_tables];

  // line address bits with the low len history bits folded on top
  function automatic logic [pht_index_bits-1:0] fold_index(
    input logic [ip_width-1:0] ip,
    input logic [hist_len-1:0] hist,
    input int unsigned         len
  );
    logic [pht_index_bits-1:0] idx;
    idx = ip[line_bytes_log +: pht_index_bits];
    for (int i = 0; i < hist_len; i++) begin
      if (i < len) begin
        idx[i % pht_index_bits] = idx[i % pht_index_bits] ^ hist[i];
      end
    end
    return idx;
  endfunction

  assign upd_en = resolve_en && resolve_mispredict;

  for (genvar t = 0; t < num_tables; t++) begin : g_table
    localparam int len = (t == 0) ? hist_len_a : (t == 1) ? hist_len_b : hist_len_c;

    logic [num_slots-1:0]      tbl [num_entries];
    logic [pht_index_bits-1:0] rd_idx;
    logic [pht_index_bits-1:0] wr_idx;

    assign rd_idx = fold_index(fetch_ip, fetch_hist, len);
    assign wr_idx = fold_index(resolve_src_ip, resolve_hist, len);

    always_ff @(posedge clk) begin
      if (rst) begin
        tbl <= '{default: '0};
      end else if (upd_en && upd_ptr == ptr_bits'(t)) begin
        tbl[wr_idx][resolve_slot] <= ~tbl[wr_idx][resolve_slot];  // one flip inverts the xor
      end
    end

    assign rd_bits[t] = tbl[rd_idx];
  end

  always_comb begin
    dir = '0;
    for (int t = 0; t < num_tables; t++) begin
      dir = dir ^ rd_bits[t];
    end
  end

  // round robin over the tables
  always_ff @(posedge clk) begin
    if (rst) begin
      upd_ptr <= '0;
    end else if (upd_en) begin
      upd_ptr <= (upd_ptr == ptr_bits'(num_tables - 1)) ? '0 : upd_ptr + 1'b1;
    end
  end

  a_ptr_in_range : assert property (
    @(posedge clk) disable iff (rst) upd_ptr < ptr_bits'(num_tables)
  ) else $error("direction_predictor: update pointer %0d out of range", upd_ptr);

endmodule

// ==== hw/next_ip_select.sv ====
// next fetch address and history
`timescale 1ns/1ns

module next_ip_select
  import fetch_addr_pkg::*;
  import branch_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetch_stall,
  input  logic                  irq_load,
  input  logic [ip_width-1:0]   irq_ip,
  input  logic                  resolve_en,
  input  logic                  resolve_mispredict,
  input  logic                  resolve_taken,
  input  logic [ip_width-1:0]   resolve_src_ip,
  input  logic [ip_width-1:0]   resolve_target,
  input  logic [hist_len-1:0]   resolve_hist,
  input  logic [num_slots-1:0]  hit,
  input  logic [ip_width-1:0]   target0,
  input  logic [ip_width-1:0]   target1,
  input  logic [kind_width-1:0] kind0,
  input  logic [kind_width-1:0] kind1,
  input  logic [num_slots-1:0]  dir,
  output logic [ip_width-1:0]   fetch_ip,
  output logic [hist_len-1:0]   fetch_hist,
  output logic                  pred_taken,
  output logic [slot_bits-1:0]  pred_slot,
  output logic                  is_call,
  output logic                  is_ret
);

  logic [num_slots-1:0]  slot_taken;
  logic [ip_width-1:0]   pred_target;
  logic [kind_width-1:0] taken_kind;
  logic [hist_len-1:0]   spec_hist;
  logic                  redirect;

  // uncond entries ignore the direction bit
  assign slot_taken[0] = hit[0] && (dir[0] || kind0[kind_uncond]);
  assign slot_taken[1] = hit[1] && (dir[1] || kind1[kind_uncond]);

  assign pred_taken  = |slot_taken;
  assign pred_slot   = slot_bits'(!slot_taken[0] && slot_taken[1]);  // slot 0 wins
  assign pred_target = slot_taken[0] ? target0 : target1;

  always_comb begin
    taken_kind = '0;
    if (slot_taken[0]) begin
      taken_kind = kind0;
    end else if (slot_taken[1]) begin
      taken_kind = kind1;
    end
  end

  assign is_call = taken_kind[kind_call];
  assign is_ret  = taken_kind[kind_ret];

  // one history bit per hit slot, stopping at the taken one
  always_comb begin
    spec_hist = fetch_hist;
    if (hit[0]) begin
      spec_hist = {spec_hist[hist_len-2:0], slot_taken[0]};
    end
    if (hit[1] && !slot_taken[0]) begin
      spec_hist = {spec_hist[hist_len-2:0], slot_taken[1]};
    end
  end

  assign redirect = resolve_en && resolve_mispredict;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip   <= '0;
      fetch_hist <= '0;
    end else if (irq_load) begin
      fetch_ip <= irq_ip;  // history kept
    end else if (redirect) begin
      fetch_ip   <= resolve_taken ? resolve_target : resolve_src_ip + line_step;
      fetch_hist <= {resolve_hist[hist_len-2:0], resolve_taken};
    end else if (!fetch_stall) begin
      fetch_ip   <= pred_taken ? pred_target : fetch_ip + line_step;
      fetch_hist <= spec_hist;
    end
  end

  a_irq_aligned : assert property (
    @(posedge clk) disable iff (rst) irq_load |-> irq_ip[line_bytes_log-1:0] == '0
  ) else $error("next_ip_select: unaligned irq_ip %h", irq_ip);

  // a buffered entry carries at most one of call and ret
  a_call_ret_excl : assert property (
    @(posedge clk) disable iff (rst) !(is_call && is_ret)
  ) else $error("next_ip_select: call and ret both set at %h", fetch_ip);

endmodule

// ==== hw/fetch_frontend.sv ====
// instruction fetch front end
`timescale 1ns/1ns

module fetch_frontend
  import fetch_addr_pkg::*;
  import branch_pkg::*;
#(
  parameter int btb_index_bits = 6,
  parameter int pht_index_bits = 6
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetch_stall,
  input  logic                  irq_load,
  input  logic [ip_width-1:0]   irq_ip,
  input  logic                  resolve_en,
  input  logic [ip_width-1:0]   resolve_src_ip,
  input  logic [ip_width-1:0]   resolve_target,
  input  logic                  resolve_taken,
  input  logic                  resolve_mispredict,
  input  logic [slot_bits-1:0]  resolve_slot,
  input  logic [kind_width-1:0] resolve_kind,
  input  logic [hist_len-1:0]   resolve_hist,
  output logic [ip_width-1:0]   fetch_ip,
  output logic [hist_len-1:0]   fetch_hist,
  output logic                  pred_taken,
  output logic [slot_bits-1:0]  pred_slot,
  output logic                  is_call,
  output logic                  is_ret
);

  logic [num_slots-1:0]  hit;
  logic [ip_width-1:0]   target0;
  logic [ip_width-1:0]   target1;
  logic [kind_width-1:0] kind0;
  logic [kind_width-1:0] kind1;
  logic [num_slots-1:0]  dir;

  // buffer and predictor both look up the current fetch line
  target_buffer #(
    .btb_index_bits(btb_index_bits)
  ) u_target_buffer (
    .clk           (clk),
    .rst           (rst),
    .fetch_ip      (fetch_ip),
    .resolve_en    (resolve_en),
    .resolve_taken (resolve_taken),
    .resolve_src_ip(resolve_src_ip),
    .resolve_target(resolve_target),
    .resolve_slot  (resolve_slot),
    .resolve_kind  (resolve_kind),
    .hit           (hit),
    .target0       (target0),
    .target1       (target1),
    .kind0         (kind0),
    .kind1         (kind1)
  );

  direction_predictor #(
    .pht_index_bits(pht_index_bits)
  ) u_direction_predictor (
    .clk               (clk),
    .rst               (rst),
    .fetch_ip          (fetch_ip),
    .fetch_hist        (fetch_hist),
    .resolve_en        (resolve_en),
    .resolve_mispredict(resolve_mispredict),
    .resolve_src_ip    (resolve_src_ip),
    .resolve_hist      (resolve_hist),
    .resolve_slot      (resolve_slot),
    .dir               (dir)
  );

  next_ip_select u_next_ip_select (
    .clk               (clk),
    .rst               (rst),
    .fetch_stall       (fetch_stall),
    .irq_load          (irq_load),
    .irq_ip            (irq_ip),
    .resolve_en        (resolve_en),
    .resolve_mispredict(resolve_mispredict),
    .resolve_taken     (resolve_taken),
    .resolve_src_ip    (resolve_src_ip),
    .resolve_target    (resolve_target),
    .resolve_hist      (resolve_hist),
    .hit               (hit),
    .target0           (target0),
    .target1           (target1),
    .kind0             (kind0),
    .kind1             (kind1),
    .dir               (dir),
    .fetch_ip          (fetch_ip),
    .fetch_hist        (fetch_hist),
    .pred_taken        (pred_taken),
    .pred_slot         (pred_slot),
    .is_call           (is_call),
    .is_ret            (is_ret)
  );

endmodule

// ==== testbench/fetch_frontend_tb.sv ====
// fetch front end testbench
`timescale 1ns/1ns

module fetch_frontend_tb
  import fetch_addr_pkg::*;
  import branch_pkg::*;
();

  localparam int clk_period = 100;
  localparam int set_bits = 6;  // DUT default btb_index_bits
  localparam int pht_bits = 6;  // DUT default pht_index_bits
  localparam int tag_lsb = line_bytes_log + set_bits;

  // per test budgets in cycles
  localparam int len_reset = 4;
  localparam int len_fall = 60;
  localparam int len_irq = 40;
  localparam int len_redirect = 20;
  localparam int len_cond = 40;
  localparam int len_kind = 30;
  localparam int len_nt = 40;
  localparam int len_margin = 50;
  localparam int watchdog_cycles = len_reset + len_fall + len_irq + len_redirect
                                 + len_cond + len_kind + len_nt + len_margin;

  localparam logic [ip_width-1:0] src_a = 43'h0_1234_5680;
  localparam logic [ip_width-1:0] tgt_a = 43'h0_0abc_0200;
  localparam logic [ip_width-1:0] src_b = 43'h0_3300_04c0;
  localparam logic [ip_width-1:0] tgt_b = 43'h0_0440_1e00;
  localparam logic [ip_width-1:0] src_c = 43'h0_5500_0100;
  localparam logic [ip_width-1:0] tgt_c0 = 43'h0_0600_0000;
  localparam logic [ip_width-1:0] tgt_c1 = 43'h0_0700_0020;
  localparam logic [ip_width-1:0] src_d = 43'h0_5500_0940;
  localparam logic [ip_width-1:0] tgt_d = 43'h0_0800_0fe0;

  logic                  clk;
  logic                  rst;
  logic                  fetch_stall;
  logic                  irq_load;
  logic [ip_width-1:0]   irq_ip;
  logic                  resolve_en;
  logic [ip_width-1:0]   resolve_src_ip;
  logic [ip_width-1:0]   resolve_target;
  logic                  resolve_taken;
  logic                  resolve_mispredict;
  logic [slot_bits-1:0]  resolve_slot;
  logic [kind_width-1:0] resolve_kind;
  logic [hist_len-1:0]   resolve_hist;
  logic [ip_width-1:0]   fetch_ip;
  logic [hist_len-1:0]   fetch_hist;
  logic                  pred_taken;
  logic [slot_bits-1:0]  pred_slot;
  logic                  is_call;
  logic                  is_ret;

  int    seed;
  string test_name;
  int    taken_seen = 0;
  int    call_seen = 0;
  int    ret_seen = 0;

  // reference model of buffer, tables and fetch registers
  logic [ip_width-1:0]        m_ip;
  logic [hist_len-1:0]        m_hist;
  logic                       m_valid [num_slots][1 << set_bits];
  logic [ip_width-tag_lsb-1:0] m_tag [num_slots][1 << set_bits];
  logic [ip_width-1:0]        m_target [num_slots][1 << set_bits];
  logic [kind_width-1:0]      m_kind [num_slots][1 << set_bits];
  logic [num_slots-1:0]       m_tbl [num_tables][1 << pht_bits];
  int                         m_ptr;

  logic                  exp_taken;
  logic [slot_bits-1:0]  exp_slot;
  logic [ip_width-1:0]   exp_target;
  logic [kind_width-1:0] exp_kind;
  logic [hist_len-1:0]   exp_hist;  // next history if fetch advances

  fetch_frontend UUT (
    .clk               (clk),
    .rst               (rst),
    .fetch_stall       (fetch_stall),
    .irq_load          (irq_load),
    .irq_ip            (irq_ip),
    .resolve_en        (resolve_en),
    .resolve_src_ip    (resolve_src_ip),
    .resolve_target    (resolve_target),
    .resolve_taken     (resolve_taken),
    .resolve_mispredict(resolve_mispredict),
    .resolve_slot      (resolve_slot),
    .resolve_kind      (resolve_kind),
    .resolve_hist      (resolve_hist),
    .fetch_ip          (fetch_ip),
    .fetch_hist        (fetch_hist),
    .pred_taken        (pred_taken),
    .pred_slot         (pred_slot),
    .is_call           (is_call),
    .is_ret            (is_ret)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic int hist_bits_of(input int t);
    case (t)
      0: return hist_len_a;
      1: return hist_len_b;
      default: return hist_len_c;
    endcase
  endfunction

  // line bits xor the used history, folded in index sized chunks
  function automatic logic [pht_bits-1:0] table_index(
    input logic [ip_width-1:0] ip,
    input logic [hist_len-1:0] hist,
    input int len
  );
    logic [3*pht_bits-1:0] used;
    used = '0;
    for (int i = 0; i < len; i++) begin
      used[i] = hist[i];
    end
    return ip[line_bytes_log +: pht_bits] ^ used[0 +: pht_bits]
         ^ used[pht_bits +: pht_bits] ^ used[2*pht_bits +: pht_bits];
  endfunction

  function automatic logic [ip_width-1:0] random_line();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return {r[ip_width-1:line_bytes_log], {line_bytes_log{1'b0}}};
  endfunction

  function automatic logic [hist_len-1:0] random_hist();
    int r;
    r = $random(seed);
    return r[hist_len-1:0];
  endfunction

  always_comb begin
    logic [set_bits-1:0]  line_set;
    logic [num_slots-1:0] hit;
    logic [num_slots-1:0] dir;
    logic [num_slots-1:0] taken;
    line_set = m_ip[line_bytes_log +: set_bits];
    dir = '0;
    for (int t = 0; t < num_tables; t++) begin
      dir = dir ^ m_tbl[t][table_index(m_ip, m_hist, hist_bits_of(t))];
    end
    for (int s = 0; s < num_slots; s++) begin
      hit[s] = m_valid[s][line_set] && m_tag[s][line_set] == m_ip[ip_width-1:tag_lsb];
      taken[s] = hit[s] && (dir[s] || m_kind[s][line_set][kind_uncond]);
    end
    exp_taken = |taken;
    exp_slot = slot_bits'(!taken[0]);
    exp_target = taken[0] ? m_target[0][line_set] : m_target[1][line_set];
    exp_kind = '0;
    if (taken[0]) begin
      exp_kind = m_kind[0][line_set];
    end else if (taken[1]) begin
      exp_kind = m_kind[1][line_set];
    end
    exp_hist = m_hist;
    if (hit[0]) exp_hist = {exp_hist[hist_len-2:0], taken[0]};
    if (hit[1] && !taken[0]) exp_hist = {exp_hist[hist_len-2:0], taken[1]};
  end

  always @(posedge clk) begin
    logic [set_bits-1:0] wr_set;
    logic [pht_bits-1:0] wr_idx;
    wr_set = resolve_src_ip[line_bytes_log +: set_bits];
    wr_idx = table_index(resolve_src_ip, resolve_hist, hist_bits_of(m_ptr));
    if (rst) begin
      m_ip <= '0;
      m_hist <= '0;
      m_ptr <= 0;
      for (int s = 0; s < num_slots; s++) begin
        for (int i = 0; i < (1 << set_bits); i++) m_valid[s][i] <= 1'b0;
      end
      for (int t = 0; t < num_tables; t++) begin
        for (int i = 0; i < (1 << pht_bits); i++) m_tbl[t][i] <= '0;
      end
    end else begin
      if (irq_load) begin
        m_ip <= irq_ip;
      end else if (resolve_en && resolve_mispredict) begin
        m_ip <= resolve_taken ? resolve_target : resolve_src_ip + line_step;
        m_hist <= {resolve_hist[hist_len-2:0], resolve_taken};
      end else if (!fetch_stall) begin
        m_ip <= exp_taken ? exp_target : m_ip + line_step;
        m_hist <= exp_hist;
      end
      if (resolve_en && resolve_taken) begin
        m_valid[resolve_slot][wr_set] <= 1'b1;
        m_tag[resolve_slot][wr_set] <= resolve_src_ip[ip_width-1:tag_lsb];
        m_target[resolve_slot][wr_set] <= resolve_target;
        m_kind[resolve_slot][wr_set] <= resolve_kind;
      end
      if (resolve_en && resolve_mispredict) begin
        m_tbl[m_ptr][wr_idx][resolve_slot] <= ~m_tbl[m_ptr][wr_idx][resolve_slot];
        m_ptr <= (m_ptr + 1) % num_tables;
      end
      if (exp_taken) taken_seen <= taken_seen + 1;
      if (exp_kind[kind_call]) call_seen <= call_seen + 1;
      if (exp_kind[kind_ret]) ret_seen <= ret_seen + 1;
    end
  end

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("error %s: %s expected %h actual %h", test_name, what, expected, actual);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  a_fetch_ip : assert property (@(posedge clk) disable iff (rst) fetch_ip == m_ip)
    else report_mismatch("fetch_ip", $sampled(m_ip), $sampled(fetch_ip));
  a_fetch_hist : assert property (@(posedge clk) disable iff (rst) fetch_hist == m_hist)
    else report_mismatch("fetch_hist", $sampled(m_hist), $sampled(fetch_hist));
  a_pred_taken : assert property (@(posedge clk) disable iff (rst) pred_taken == exp_taken)
    else report_mismatch("pred_taken", $sampled(exp_taken), $sampled(pred_taken));
  a_pred_slot : assert property (
    @(posedge clk) disable iff (rst) exp_taken |-> pred_slot == exp_slot
  ) else report_mismatch("pred_slot", $sampled(exp_slot), $sampled(pred_slot));
  a_is_call : assert property (@(posedge clk) disable iff (rst) is_call == exp_kind[kind_call])
    else report_mismatch("is_call", $sampled(exp_kind[kind_call]), $sampled(is_call));
  a_is_ret : assert property (@(posedge clk) disable iff (rst) is_ret == exp_kind[kind_ret])
    else report_mismatch("is_ret", $sampled(exp_kind[kind_ret]), $sampled(is_ret));

  task automatic run_cycles(input int n, input bit random_stall);
    int r;
    repeat (n) begin
      @(posedge clk);
      r = $random(seed);
      fetch_stall <= random_stall && r[0];
      irq_load <= 1'b0;
      resolve_en <= 1'b0;
    end
  endtask

  task automatic jump_to(input logic [ip_width-1:0] ip, input logic stall);
    @(posedge clk);
    irq_load <= 1'b1;
    irq_ip <= ip;
    fetch_stall <= stall;
    resolve_en <= 1'b0;
    @(posedge clk);
    irq_load <= 1'b0;
  endtask

  task automatic resolve_branch(
    input logic [ip_width-1:0]   src,
    input logic [ip_width-1:0]   tgt,
    input logic                  taken,
    input logic                  mispredict,
    input logic [slot_bits-1:0]  slot,
    input logic [kind_width-1:0] kind,
    input logic [hist_len-1:0]   hist,
    input logic                  stall
  );
    @(posedge clk);
    resolve_en <= 1'b1;
    resolve_src_ip <= src;
    resolve_target <= tgt;
    resolve_taken <= taken;
    resolve_mispredict <= mispredict;
    resolve_slot <= slot;
    resolve_kind <= kind;
    resolve_hist <= hist;
    fetch_stall <= stall;
    irq_load <= 1'b0;
    @(posedge clk);
    resolve_en <= 1'b0;
    resolve_mispredict <= 1'b0;
  endtask

  // redirect that lands on ip with exactly hist, then stays stalled there
  task automatic place_at(input logic [ip_width-1:0] ip, input logic [hist_len-1:0] hist);
    resolve_branch(ip - line_step, ip, hist[0], 1'b1, '0, '0, hist >> 1, 1'b1);
  endtask

  initial begin
    logic [hist_len-1:0] seen_hist;
    seed = 48;
    test_name = "reset";
    rst <= 1'b1;
    fetch_stall <= 1'b0;
    irq_load <= 1'b0;
    irq_ip <= '0;
    resolve_en <= 1'b0;
    resolve_src_ip <= '0;
    resolve_target <= '0;
    resolve_taken <= 1'b0;
    resolve_mispredict <= 1'b0;
    resolve_slot <= '0;
    resolve_kind <= '0;
    resolve_hist <= '0;
    repeat (len_reset) @(posedge clk);
    rst <= 1'b0;

    test_name = "fall_through";
    run_cycles(len_fall, 1'b1);

    test_name = "irq_load";
    repeat (4) begin
      jump_to(random_line(), 1'b0);
      run_cycles(6, 1'b1);
    end

    test_name = "redirect_uncond";
    resolve_branch(src_a, tgt_a, 1'b1, 1'b1, '0, 3'b100, 14'h2a5, 1'b0);
    run_cycles(5, 1'b1);
    jump_to(src_a, 1'b0);
    run_cycles(3, 1'b0);

    // learning stays in slot 1, place_at only flips slot 0 bits
    test_name = "cond_learning";
    resolve_branch(src_b, tgt_b, 1'b1, 1'b0, 1'b1, 3'b000, '0, 1'b0);
    place_at(src_b, 14'h1b3);
    @(negedge clk);
    seen_hist = fetch_hist;
    run_cycles(1, 1'b0);
    resolve_branch(src_b, tgt_b, 1'b1, 1'b1, 1'b1, 3'b000, seen_hist, 1'b1);
    place_at(src_b, seen_hist);
    run_cycles(1, 1'b0);
    resolve_branch(src_b, tgt_b, 1'b0, 1'b1, 1'b1, 3'b000, seen_hist, 1'b1);
    place_at(src_b, seen_hist);
    run_cycles(2, 1'b0);

    test_name = "call_ret";
    resolve_branch(src_c, tgt_c0, 1'b1, 1'b0, 1'b0, 3'b101, '0, 1'b0);
    resolve_branch(src_c, tgt_c1, 1'b1, 1'b0, 1'b1, 3'b110, '0, 1'b0);
    resolve_branch(src_d, tgt_d, 1'b1, 1'b0, 1'b1, 3'b110, '0, 1'b0);
    jump_to(src_c, 1'b0);
    run_cycles(2, 1'b0);
    jump_to(src_d, 1'b0);
    run_cycles(2, 1'b0);

    test_name = "not_taken_redirect";
    repeat (6) begin
      resolve_branch(random_line(), random_line(), 1'b0, 1'b1, '0, '0, random_hist(), 1'b0);
      run_cycles(4, 1'b1);
    end

    @(posedge clk);
    if (taken_seen == 0 || call_seen == 0 || ret_seen == 0) begin
      $display("stimulus never reached a predicted taken, call or ret fetch");
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

endmodule

// ==== fetch_frontend.f ====
hw/fetch_addr_pkg.sv
hw/branch_pkg.sv
hw/target_buffer.sv
hw/direction_predictor.sv
hw/next_ip_select.sv
hw/fetch_frontend.sv
testbench/fetch_frontend_tb.sv

// ==== Makefile ====
# fetch front end simulation with verilator

TOP = fetch_frontend_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f fetch_frontend.f

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed" ; exit 1)

clean:
	rm -rf obj_dir $(LOG)
